//--- common/user_logic_settings.svh
`ifndef USER_LOGIC_SETTINGS_SVH
`define USER_LOGIC_SETTINGS_SVH

// streams per class, host (pcie) and memory (ddr).
`define UL_NUM_STREAMS    4
`define UL_DATA_W         64
`define UL_ADDR_W         20
`define UL_CNT_W          16

// host register map.
`define UL_REG_CONTROL    20'h400
`define UL_REG_THRESH     20'h408
// eight counters, 4 bytes apart. pcie 0..3 then ddr 0..3.
`define UL_REG_COUNT_BASE 20'h410

`endif

//--- common/host_reg_pkg.sv
`default_nettype none

`include "user_logic_settings.svh"

package host_reg_pkg;

    localparam int REG_W = 32;

    // request from the framework's host side.
    typedef struct packed {
        logic                  wr_req;
        logic                  rd_req;
        logic [`UL_ADDR_W-1:0] addr;
        logic [REG_W-1:0]      wr_data;
    } host_req_t;

    // rd_data is valid in the cycle rd_ack is high.
    typedef struct packed {
        logic             rd_ack;
        logic [REG_W-1:0] rd_data;
    } host_rsp_t;

endpackage

`default_nettype wire

//--- common/stream_pkg.sv
`default_nettype none

`include "user_logic_settings.svh"

package stream_pkg;

    typedef struct packed {
        logic [`UL_DATA_W-1:0] data;
        logic                  last;
    } pcie_beat_t;

    typedef struct packed {
        logic [`UL_DATA_W-1:0] data;
    } ddr_beat_t;

    // memory streams sit in the upper half.
    typedef struct packed {
        logic [`UL_NUM_STREAMS-1:0] ddr;
        logic [`UL_NUM_STREAMS-1:0] pcie;
    } stream_flags_t;

endpackage

`default_nettype wire

//--- hw/stream_stage.sv
`default_nettype none

module stream_stage #(
    parameter type beat_t = logic [63:0]
) (
    input  wire logic  i_pcie_clk,
    input  wire logic  i_reset,
    input  wire logic  i_enable,
    input  wire logic  i_valid,
    output logic       o_ack,
    input  wire beat_t i_beat,
    output logic       o_valid,
    input  wire logic  i_ack,
    output beat_t      o_beat
);

    logic  full;
    logic  load;
    beat_t beat_q;

    // empty or draining this cycle.
    assign o_ack = i_enable && (!full || i_ack);
    assign load  = i_valid && o_ack;

    always_ff @(posedge i_pcie_clk)
    begin
        if (i_reset)
        begin
            full <= 1'b0;
        end
        else if (load)
        begin
            full <= 1'b1;
        end
        else if (i_ack)
        begin
            full <= 1'b0; // drains even when disabled.
        end
    end

    always_ff @(posedge i_pcie_clk)
    begin
        if (load)
        begin
            beat_q <= i_beat;
        end
    end

    assign o_valid = full;
    assign o_beat  = beat_q;

endmodule

`default_nettype wire

//--- user_logic/user_regs.sv
`default_nettype none

`include "user_logic_settings.svh"

module user_regs (
    input  wire logic                    i_pcie_clk,
    input  wire logic                    i_reset,
    input  wire host_reg_pkg::host_req_t i_req,
    output host_reg_pkg::host_rsp_t      o_rsp,
    input  wire logic [2*`UL_NUM_STREAMS-1:0][`UL_CNT_W-1:0] i_counts,
    output stream_pkg::stream_flags_t    o_enable,
    output logic                         o_count_clear,
    output logic                         o_intr_req,
    input  wire logic                    i_intr_ack
);

    localparam int NUM_CNT = 2 * `UL_NUM_STREAMS;

    logic [31:0] control;
    logic [31:0] thresh;
    logic [31:0] rd_data;
    logic [31:0] rd_data_q;
    logic        rd_ack_q;
    logic        hit;
    logic        armed;
    logic        fire;

    assign o_count_clear = i_req.wr_req && (i_req.addr == `UL_REG_THRESH);

    always_ff @(posedge i_pcie_clk)
    begin
        if (i_reset)
        begin
            control <= '0;
            thresh  <= '0;
        end
        else if (i_req.wr_req)
        begin
            if (i_req.addr == `UL_REG_CONTROL)
                control <= i_req.wr_data;
            if (i_req.addr == `UL_REG_THRESH)
                thresh <= i_req.wr_data;
        end
    end

    assign o_enable = control[NUM_CNT-1:0];

    // unmapped addresses read as zero.
    always_comb
    begin
        rd_data = '0;
        if (i_req.addr == `UL_REG_CONTROL)
            rd_data = control;
        else if (i_req.addr == `UL_REG_THRESH)
            rd_data = thresh;
        for (int i = 0; i < NUM_CNT; i++)
        begin
            if (i_req.addr == `UL_ADDR_W'(`UL_REG_COUNT_BASE + 4 * i))
                rd_data = 32'(i_counts[i]);
        end
    end

    always_ff @(posedge i_pcie_clk)
    begin
        if (i_reset)
            rd_ack_q <= 1'b0;
        else
            rd_ack_q <= i_req.rd_req;
    end

    always_ff @(posedge i_pcie_clk)
    begin
        rd_data_q <= rd_data;
    end

    assign o_rsp.rd_ack  = rd_ack_q;
    assign o_rsp.rd_data = rd_data_q;

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < NUM_CNT; i++)
        begin
            if (control[i] && (32'(i_counts[i]) >= thresh))
                hit = 1'b1;
        end
    end

    // one request per threshold crossing, rearmed when counters clear.
    assign fire = control[31] && armed && hit;

    always_ff @(posedge i_pcie_clk)
    begin
        if (i_reset)
        begin
            armed      <= 1'b1;
            o_intr_req <= 1'b0;
        end
        else
        begin
            if (o_count_clear)
                armed <= 1'b1;
            else if (fire)
                armed <= 1'b0;

            if (o_intr_req && i_intr_ack)
                o_intr_req <= 1'b0;
            else if (fire)
                o_intr_req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- user_logic/stream_bank.sv
`default_nettype none

`include "user_logic_settings.svh"

module stream_bank (
    input  wire logic                       i_pcie_clk,
    input  wire logic                       i_reset,
    input  wire stream_pkg::stream_flags_t  i_enable,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_pcie_valid,
    output logic [`UL_NUM_STREAMS-1:0]      o_pcie_ack,
    output logic [`UL_NUM_STREAMS-1:0]      o_pcie_valid,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_pcie_ack,
    input  wire stream_pkg::pcie_beat_t [`UL_NUM_STREAMS-1:0] i_pcie_beat,
    output stream_pkg::pcie_beat_t [`UL_NUM_STREAMS-1:0]      o_pcie_beat,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_ddr_valid,
    output logic [`UL_NUM_STREAMS-1:0]      o_ddr_ack,
    output logic [`UL_NUM_STREAMS-1:0]      o_ddr_valid,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_ddr_ack,
    input  wire stream_pkg::ddr_beat_t [`UL_NUM_STREAMS-1:0] i_ddr_beat,
    output stream_pkg::ddr_beat_t [`UL_NUM_STREAMS-1:0]      o_ddr_beat,
    input  wire logic                       i_count_clear,
    output logic [2*`UL_NUM_STREAMS-1:0][`UL_CNT_W-1:0] o_counts
);

    import stream_pkg::*;

    logic [2*`UL_NUM_STREAMS-1:0] xfer;

    for (genvar i = 0; i < `UL_NUM_STREAMS; i++)
    begin : g_pcie
        stream_stage #(.beat_t(pcie_beat_t)) u_stage (
            .i_pcie_clk (i_pcie_clk),
            .i_reset    (i_reset),
            .i_enable   (i_enable.pcie[i]),
            .i_valid    (i_pcie_valid[i]),
            .o_ack      (o_pcie_ack[i]),
            .i_beat     (i_pcie_beat[i]),
            .o_valid    (o_pcie_valid[i]),
            .i_ack      (i_pcie_ack[i]),
            .o_beat     (o_pcie_beat[i])
        );
    end

    for (genvar i = 0; i < `UL_NUM_STREAMS; i++)
    begin : g_ddr
        stream_stage #(.beat_t(ddr_beat_t)) u_stage (
            .i_pcie_clk (i_pcie_clk),
            .i_reset    (i_reset),
            .i_enable   (i_enable.ddr[i]),
            .i_valid    (i_ddr_valid[i]),
            .o_ack      (o_ddr_ack[i]),
            .i_beat     (i_ddr_beat[i]),
            .o_valid    (o_ddr_valid[i]),
            .i_ack      (i_ddr_ack[i]),
            .o_beat     (o_ddr_beat[i])
        );
    end

    // same order as the enable flags.
    assign xfer = {o_ddr_valid & i_ddr_ack, o_pcie_valid & i_pcie_ack};

    always_ff @(posedge i_pcie_clk)
    begin
        for (int i = 0; i < 2 * `UL_NUM_STREAMS; i++)
        begin
            if (i_reset || i_count_clear)
                o_counts[i] <= '0;
            else if (xfer[i] && (o_counts[i] != '1))
                o_counts[i] <= o_counts[i] + 1'b1; // saturates.
        end
    end

endmodule

`default_nettype wire

//--- user_logic/user_logic.sv
`default_nettype none

`include "user_logic_settings.svh"

module user_logic (
    input  wire logic                       i_pcie_clk,
    input  wire logic                       i_reset,
    input  wire host_reg_pkg::host_req_t    i_host_req,
    output host_reg_pkg::host_rsp_t         o_host_rsp,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_pcie_valid,
    output logic [`UL_NUM_STREAMS-1:0]      o_pcie_ack,
    input  wire stream_pkg::pcie_beat_t [`UL_NUM_STREAMS-1:0] i_pcie_beat,
    output logic [`UL_NUM_STREAMS-1:0]      o_pcie_valid,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_pcie_ack,
    output stream_pkg::pcie_beat_t [`UL_NUM_STREAMS-1:0]      o_pcie_beat,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_ddr_valid,
    output logic [`UL_NUM_STREAMS-1:0]      o_ddr_ack,
    input  wire stream_pkg::ddr_beat_t [`UL_NUM_STREAMS-1:0] i_ddr_beat,
    output logic [`UL_NUM_STREAMS-1:0]      o_ddr_valid,
    input  wire logic [`UL_NUM_STREAMS-1:0] i_ddr_ack,
    output stream_pkg::ddr_beat_t [`UL_NUM_STREAMS-1:0]      o_ddr_beat,
    output logic                            o_intr_req,
    input  wire logic                       i_intr_ack
);

    import stream_pkg::*;

    stream_flags_t                              enable;
    logic                                       count_clear;
    logic [2*`UL_NUM_STREAMS-1:0][`UL_CNT_W-1:0] counts;

    user_regs u_regs (
        .i_pcie_clk    (i_pcie_clk),
        .i_reset       (i_reset),
        .i_req         (i_host_req),
        .o_rsp         (o_host_rsp),
        .i_counts      (counts),
        .o_enable      (enable),
        .o_count_clear (count_clear),
        .o_intr_req    (o_intr_req),
        .i_intr_ack    (i_intr_ack)
    );

    stream_bank u_bank (
        .i_pcie_clk    (i_pcie_clk),
        .i_reset       (i_reset),
        .i_enable      (enable),
        .i_pcie_valid  (i_pcie_valid),
        .o_pcie_ack    (o_pcie_ack),
        .o_pcie_valid  (o_pcie_valid),
        .i_pcie_ack    (i_pcie_ack),
        .i_pcie_beat   (i_pcie_beat),
        .o_pcie_beat   (o_pcie_beat),
        .i_ddr_valid   (i_ddr_valid),
        .o_ddr_ack     (o_ddr_ack),
        .o_ddr_valid   (o_ddr_valid),
        .i_ddr_ack     (i_ddr_ack),
        .i_ddr_beat    (i_ddr_beat),
        .o_ddr_beat    (o_ddr_beat),
        .i_count_clear (count_clear),
        .o_counts      (counts)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // reset is seen high on the first RESET_CYCLES rising edges.
    initial
    begin
        o_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/user_logic_assert.sv
`default_nettype none

`include "user_logic_settings.svh"

module user_logic_assert (
    input wire logic i_pcie_clk,
    input wire logic i_reset,
    input wire logic i_rd_req,
    input wire logic i_rd_ack,
    input wire logic i_intr_en,
    input wire logic i_intr_req,
    input wire logic [2*`UL_NUM_STREAMS-1:0] i_valid,
    input wire logic [2*`UL_NUM_STREAMS-1:0] i_ack,
    input wire stream_pkg::pcie_beat_t [`UL_NUM_STREAMS-1:0] i_pcie_beat,
    input wire stream_pkg::ddr_beat_t [`UL_NUM_STREAMS-1:0]  i_ddr_beat
);

    localparam int NH = `UL_NUM_STREAMS;

    // a stalled output keeps its beat.
    for (genvar i = 0; i < NH; i++)
    begin : g_hold
        pcie_hold: assert property (@(posedge i_pcie_clk) disable iff (i_reset)
            i_valid[i] && !i_ack[i] |=> i_valid[i] && $stable(i_pcie_beat[i]))
            else $error("pcie stream %0d beat changed under back-pressure", i);
        ddr_hold: assert property (@(posedge i_pcie_clk) disable iff (i_reset)
            i_valid[NH+i] && !i_ack[NH+i] |=> i_valid[NH+i] && $stable(i_ddr_beat[i]))
            else $error("ddr stream %0d beat changed under back-pressure", i);
    end

    rd_ack_after_req: assert property (@(posedge i_pcie_clk) disable iff (i_reset)
        i_rd_req |=> i_rd_ack)
        else $error("read request not acknowledged one cycle later");

    rd_ack_only_after_req: assert property (@(posedge i_pcie_clk) disable iff (i_reset)
        !i_rd_req |=> !i_rd_ack)
        else $error("read acknowledge without a request");

    no_intr_when_disabled: assert property (@(posedge i_pcie_clk) disable iff (i_reset)
        !i_intr_en && !i_intr_req |=> !i_intr_req)
        else $error("interrupt raised with the interrupt enable clear");

endmodule

bind user_regs user_logic_assert regs_assert_i (
    .i_pcie_clk  (i_pcie_clk),
    .i_reset     (i_reset),
    .i_rd_req    (i_req.rd_req),
    .i_rd_ack    (o_rsp.rd_ack),
    .i_intr_en   (control[31]),
    .i_intr_req  (o_intr_req),
    .i_valid     ('0),
    .i_ack       ('0),
    .i_pcie_beat ('0),
    .i_ddr_beat  ('0)
);

bind stream_bank user_logic_assert bank_assert_i (
    .i_pcie_clk  (i_pcie_clk),
    .i_reset     (i_reset),
    .i_rd_req    (1'b0),
    .i_rd_ack    (1'b0),
    .i_intr_en   (1'b0),
    .i_intr_req  (1'b0),
    .i_valid     ({o_ddr_valid, o_pcie_valid}),
    .i_ack       ({i_ddr_ack, i_pcie_ack}),
    .i_pcie_beat (o_pcie_beat),
    .i_ddr_beat  (o_ddr_beat)
);

`default_nettype wire

//--- tests/user_logic_tb.sv
`default_nettype none

`include "user_logic_settings.svh"

module user_logic_tb;

    import host_reg_pkg::*;
    import stream_pkg::*;

    localparam int NH          = `UL_NUM_STREAMS;
    localparam int NS          = 2 * NH;
    localparam int SEED        = 35975;
    localparam int RUN_CYCLES  = 150 + 100 + 60 + 150 + 120 + 10;
    localparam int REG_CYCLES  = 100; // upper bound on register reads and writes.
    localparam int TEST_CYCLES = RUN_CYCLES + REG_CYCLES + 4;
    localparam int TIMEOUT     = TEST_CYCLES * 8 + 200;

    typedef logic [64:0] chk_t;

    logic pcie_clk;
    logic reset;
    logic traffic_on;
    host_req_t host_req;
    host_rsp_t host_rsp;
    logic [NH-1:0] pcie_in_valid, pcie_in_ack, pcie_out_valid, pcie_out_ack;
    logic [NH-1:0] ddr_in_valid, ddr_in_ack, ddr_out_valid, ddr_out_ack;
    pcie_beat_t [NH-1:0] pcie_in_beat, pcie_out_beat;
    ddr_beat_t [NH-1:0]  ddr_in_beat, ddr_out_beat;
    logic intr_req;
    logic intr_ack;

    // reference model state.
    chk_t                 exp_q [NS][$];
    logic [31:0]          m_control, m_thresh, m_rd_data;
    logic [`UL_CNT_W-1:0] m_count [NS];
    logic                 m_intr, m_armed, m_rd_ack;
    int                   intr_rises;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(2)) clock_i (
        .o_clk   (pcie_clk),
        .o_reset (reset)
    );

    user_logic dut_i (
        .i_pcie_clk   (pcie_clk),
        .i_reset      (reset),
        .i_host_req   (host_req),
        .o_host_rsp   (host_rsp),
        .i_pcie_valid (pcie_in_valid),
        .o_pcie_ack   (pcie_in_ack),
        .i_pcie_beat  (pcie_in_beat),
        .o_pcie_valid (pcie_out_valid),
        .i_pcie_ack   (pcie_out_ack),
        .o_pcie_beat  (pcie_out_beat),
        .i_ddr_valid  (ddr_in_valid),
        .o_ddr_ack    (ddr_in_ack),
        .i_ddr_beat   (ddr_in_beat),
        .o_ddr_valid  (ddr_out_valid),
        .i_ddr_ack    (ddr_out_ack),
        .o_ddr_beat   (ddr_out_beat),
        .o_intr_req   (intr_req),
        .i_intr_ack   (intr_ack)
    );

    task automatic check(input string name, input chk_t got, input chk_t exp);
        if (got !== exp)
        begin
            $display("error %s expected %h got %h", name, exp, got);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic string signal_name(input int s, input string sig);
        if (s < NH)
            return $sformatf("o_pcie_%s[%0d]", sig, s);
        return $sformatf("o_ddr_%s[%0d]", sig, s - NH);
    endfunction

    function automatic chk_t in_beat_of(input int s);
        if (s < NH)
            return chk_t'(pcie_in_beat[s]);
        return chk_t'(ddr_in_beat[s - NH]);
    endfunction

    function automatic chk_t out_beat_of(input int s);
        if (s < NH)
            return chk_t'(pcie_out_beat[s]);
        return chk_t'(ddr_out_beat[s - NH]);
    endfunction

    // counters sit 4 bytes apart from the count base.
    function automatic logic [31:0] model_read(input logic [`UL_ADDR_W-1:0] addr);
        if (addr == `UL_REG_CONTROL)
            return m_control;
        if (addr == `UL_REG_THRESH)
            return m_thresh;
        for (int i = 0; i < NS; i++)
        begin
            if (addr == `UL_ADDR_W'(`UL_REG_COUNT_BASE + 4 * i))
                return 32'(m_count[i]);
        end
        return 32'h0;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < NS; s++)
        begin
            exp_q[s].delete();
            m_count[s] = '0;
        end
        m_control  = '0;
        m_thresh   = '0;
        m_rd_ack   = 1'b0;
        m_rd_data  = '0;
        m_intr     = 1'b0;
        m_armed    = 1'b1;
        intr_rises = 0;
    endtask

    task automatic model_cycle();
        logic [NS-1:0] in_valid, in_ack, out_valid, out_ack;
        logic hit;
        logic fire;
        logic clear;
        in_valid  = {ddr_in_valid, pcie_in_valid};
        in_ack    = {ddr_in_ack, pcie_in_ack};
        out_valid = {ddr_out_valid, pcie_out_valid};
        out_ack   = {ddr_out_ack, pcie_out_ack};
        check("o_intr_req", chk_t'(intr_req), chk_t'(m_intr));
        check("o_host_rsp.rd_ack", chk_t'(host_rsp.rd_ack), chk_t'(m_rd_ack));
        if (m_rd_ack)
            check("o_host_rsp.rd_data", chk_t'(host_rsp.rd_data), chk_t'(m_rd_data));
        hit = 1'b0;
        for (int s = 0; s < NS; s++)
        begin
            check(signal_name(s, "ack"), chk_t'(in_ack[s]),
                  chk_t'(m_control[s] && (exp_q[s].size() == 0 || out_ack[s])));
            check(signal_name(s, "valid"), chk_t'(out_valid[s]), chk_t'(exp_q[s].size() != 0));
            if (m_control[s] && (32'(m_count[s]) >= m_thresh))
                hit = 1'b1;
        end
        fire  = m_control[31] && m_armed && hit;
        clear = host_req.wr_req && (host_req.addr == `UL_REG_THRESH);
        m_rd_ack  = host_req.rd_req;
        m_rd_data = model_read(host_req.addr);
        for (int s = 0; s < NS; s++)
        begin
            if (out_valid[s] && out_ack[s])
            begin
                check(signal_name(s, "beat"), out_beat_of(s), exp_q[s].pop_front());
                if (m_count[s] != '1)
                    m_count[s] = m_count[s] + 1'b1;
            end
            if (clear)
                m_count[s] = '0;
            if (in_valid[s] && in_ack[s])
                exp_q[s].push_back(in_beat_of(s));
        end
        if (m_intr && intr_ack)
            m_intr = 1'b0;
        else if (fire)
            m_intr = 1'b1;
        if (fire)
            intr_rises++;
        if (clear)
            m_armed = 1'b1;
        else if (fire)
            m_armed = 1'b0;
        if (host_req.wr_req && host_req.addr == `UL_REG_CONTROL)
            m_control = host_req.wr_data;
        if (clear)
            m_thresh = host_req.wr_data;
    endtask

    always @(posedge pcie_clk)
    begin
        if (reset)
            model_reset();
        else
            model_cycle();
    end

    task automatic drive_traffic();
        pcie_beat_t [NH-1:0] pb;
        ddr_beat_t [NH-1:0]  db;
        for (int i = 0; i < NH; i++)
        begin
            pb[i].data = {$urandom, $urandom};
            pb[i].last = 1'($urandom);
            db[i].data = {$urandom, $urandom};
        end
        if (traffic_on)
        begin
            pcie_in_valid <= NH'($urandom);
            ddr_in_valid  <= NH'($urandom);
            pcie_out_ack  <= NH'($urandom | $urandom); // mostly ready.
            ddr_out_ack   <= NH'($urandom | $urandom);
            intr_ack      <= (($urandom % 3) == 0);
        end
        else
        begin
            pcie_in_valid <= '0;
            ddr_in_valid  <= '0;
            pcie_out_ack  <= '1;
            ddr_out_ack   <= '1;
            intr_ack      <= 1'b0;
        end
        pcie_in_beat <= pb;
        ddr_in_beat  <= db;
    endtask

    task automatic step(input host_req_t req);
        @(posedge pcie_clk);
        drive_traffic();
        host_req <= req;
    endtask

    task automatic run(input int n);
        repeat (n) step('0);
    endtask

    task automatic reg_write(input logic [`UL_ADDR_W-1:0] addr, input logic [31:0] data);
        host_req_t req;
        req         = '0;
        req.wr_req  = 1'b1;
        req.addr    = addr;
        req.wr_data = data;
        step(req);
    endtask

    task automatic reg_read(input logic [`UL_ADDR_W-1:0] addr);
        host_req_t req;
        req        = '0;
        req.rd_req = 1'b1;
        req.addr   = addr;
        step(req);
    endtask

    task automatic read_counts();
        for (int i = 0; i < NS; i++)
            reg_read(`UL_ADDR_W'(`UL_REG_COUNT_BASE + 4 * i));
    endtask

    task automatic read_all();
        reg_read(`UL_REG_CONTROL);
        reg_read(`UL_REG_THRESH);
        read_counts();
        reg_read(20'h7fc);
    endtask

    initial
    begin
        #(TIMEOUT);
        $display("timeout: the test did not complete within %0d time units", TIMEOUT);
        $display("Finished with errors");
        $fatal(1);
    end

    initial
    begin
        void'($urandom(SEED));
        traffic_on    = 1'b0;
        host_req      <= '0;
        pcie_in_valid <= '0;
        pcie_out_ack  <= '0;
        pcie_in_beat  <= '0;
        ddr_in_valid  <= '0;
        ddr_out_ack   <= '0;
        ddr_in_beat   <= '0;
        intr_ack      <= 1'b0;
        @(posedge pcie_clk);
        while (reset)
            @(posedge pcie_clk);
        read_all();
        reg_write(`UL_REG_THRESH, 32'd3);
        reg_write(`UL_REG_CONTROL, 32'h0000_00ff);
        reg_read(`UL_REG_CONTROL);
        reg_read(`UL_REG_THRESH);
        reg_read(20'h404);
        traffic_on = 1'b1;
        run(150); // interrupt enable still clear.
        read_counts();
        reg_write(`UL_REG_CONTROL, 32'h0000_005a);
        run(100);
        read_counts();
        reg_write(`UL_REG_CONTROL, 32'h0000_00ff);
        run(60);
        read_counts();
        reg_write(`UL_REG_THRESH, 32'd20);
        reg_write(`UL_REG_CONTROL, 32'h8000_00ff);
        run(150);
        read_counts();
        reg_write(`UL_REG_THRESH, 32'd25); // clears counters and rearms.
        run(120);
        read_all();
        traffic_on = 1'b0;
        run(10);
        if (intr_rises < 2)
        begin
            $display("fewer than two interrupt requests were raised during the run");
            $display("Finished with errors");
            $fatal(1);
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/host_reg_pkg.sv
common/stream_pkg.sv
hw/stream_stage.sv
user_logic/user_regs.sv
user_logic/stream_bank.sv
user_logic/user_logic.sv
tests/tb_clock.sv
tests/user_logic_assert.sv
tests/user_logic_tb.sv

//--- Makefile
# Verilator build for the user logic testbench.

VERILATOR ?= verilator
TOP       ?= user_logic_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
